// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    parameter int XLEN = 32;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_LD_BU,
        OP_LD_HU,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } mem_op_e;

    // incoming instruction, wdata is the ALU result for OP_NOP
    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wreg;
        logic [4:0]      waddr;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            wreg;
        logic [4:0]      waddr;
        logic            mem_access_valid;
    } mem2_mem3_t;

    typedef struct packed {
        logic            valid;
        logic            wreg;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
    } mem3_wb_t;

    typedef struct packed {
        logic            wreg;
        logic            ok;
        logic [4:0]      waddr;
        logic [XLEN-1:0] wdata;
    } data_forward_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

endpackage

`default_nettype wire

// ==== hdl/mem2_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem2_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       advance_i,
    input  logic                       flush_i,
    input  lsu_pkg::lsu_req_t          req_i,
    output lsu_pkg::mem2_mem3_t        mem2_o,
    output logic                       req_o,
    output logic                       we_o,
    output logic [lsu_pkg::XLEN-1:0]   addr_o,
    output logic [3:0]                 wstrb_o,
    output logic [lsu_pkg::XLEN-1:0]   wdata_o
);
    lsu_pkg::lsu_req_t   mem2_q;
    lsu_pkg::mem2_mem3_t mem2_d;

    always_comb begin
        mem2_d.valid            = mem2_q.valid;
        mem2_d.op               = mem2_q.op;
        mem2_d.addr             = mem2_q.addr;
        mem2_d.wdata            = mem2_q.wdata;
        mem2_d.wreg             = mem2_q.wreg;
        mem2_d.waddr            = mem2_q.waddr;
        mem2_d.mem_access_valid = mem2_q.valid
            & (lsu_pkg::is_load(mem2_q.op) | lsu_pkg::is_store(mem2_q.op));
    end

    // mem2 and the mem3 register move together on advance
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2_q <= '0;
            mem2_o <= '0;
        end else if (advance_i) begin
            mem2_q <= req_i;
            mem2_o <= mem2_d;
        end
    end

    // request leaves with the instruction
    assign req_o  = advance_i & ~flush_i & mem2_d.mem_access_valid;
    assign we_o   = lsu_pkg::is_store(mem2_q.op);
    assign addr_o = mem2_q.addr;

    always_comb begin
        wstrb_o = 4'b0000;
        wdata_o = mem2_q.wdata;
        case (mem2_q.op)
            lsu_pkg::OP_ST_B: begin
                wstrb_o = 4'b0001 << mem2_q.addr[1:0];
                wdata_o = {4{mem2_q.wdata[7:0]}};
            end
            lsu_pkg::OP_ST_H: begin
                wstrb_o = mem2_q.addr[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{mem2_q.wdata[15:0]}};
            end
            lsu_pkg::OP_ST_W: begin
                wstrb_o = 4'b1111;
            end
            default: begin
                wstrb_o = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module dcache_ram #(
    parameter int DEPTH_LOG2 = 8,
    parameter int LATENCY    = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [lsu_pkg::XLEN-1:0]   addr_i,
    input  logic [3:0]                 wstrb_i,
    input  logic [lsu_pkg::XLEN-1:0]   wdata_i,
    output logic                       data_ok_o,
    output logic [lsu_pkg::XLEN-1:0]   rdata_o
);
    logic [lsu_pkg::XLEN-1:0] mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0]    index;
    logic [lsu_pkg::XLEN-1:0] merged;
    logic [LATENCY-1:0]       pend_q;

    // word index, byte offset dropped
    assign index = addr_i[DEPTH_LOG2+1:2];

    always_comb begin
        merged = mem[index];
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb_i[b]) begin
                    merged[8*b +: 8] = wdata_i[8*b +: 8];
                end
            end
        end
    end

    // store lands on the request edge, read returns the merged word
    always_ff @(posedge clk) begin
        if (req_i) begin
            if (we_i) begin
                mem[index] <= merged;
            end
            rdata_o <= merged;
        end
    end

    // response delay line
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            pend_q <= '0;
        end else begin
            pend_q[0] <= req_i;
            for (int i = 1; i < LATENCY; i++) begin
                pend_q[i] <= pend_q[i-1];
            end
        end
    end

    assign data_ok_o = pend_q[LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/mem3_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem3_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        advance_i,
    input  logic                        flush_i,
    input  lsu_pkg::mem2_mem3_t         mem2_i,
    input  logic                        data_ok_i,
    input  logic [lsu_pkg::XLEN-1:0]    cache_data_i,
    output logic                        advance_ready_o,
    output lsu_pkg::data_forward_t      data_forward_o,
    output lsu_pkg::mem3_wb_t           wb_o
);
    logic                     load_op;
    logic                     data_already_ok;
    logic [lsu_pkg::XLEN-1:0] cache_data_early;
    logic [lsu_pkg::XLEN-1:0] cache_data;
    logic [7:0]               byte_sel;
    logic [15:0]              half_sel;
    logic [lsu_pkg::XLEN-1:0] load_data;
    lsu_pkg::mem3_wb_t        wb_d;

    assign load_op = lsu_pkg::is_load(mem2_i.op) & mem2_i.mem_access_valid;

    // remember a data_ok seen while stalled
    always_ff @(posedge clk) begin
        if (rst || flush_i || advance_i) begin
            data_already_ok <= 1'b0;
        end else if (data_ok_i) begin
            data_already_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok_i) begin
            cache_data_early <= cache_data_i;
        end
    end

    assign cache_data = data_already_ok ? cache_data_early : cache_data_i;

    assign advance_ready_o = ~mem2_i.mem_access_valid | data_ok_i | data_already_ok;

    // lane select
    assign byte_sel = cache_data[{mem2_i.addr[1:0], 3'b000} +: 8];
    assign half_sel = mem2_i.addr[1] ? cache_data[31:16] : cache_data[15:0];

    always_comb begin
        load_data = cache_data;
        case (mem2_i.op)
            lsu_pkg::OP_LD_B:
                load_data = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::OP_LD_BU:
                load_data = {24'b0, byte_sel};
            lsu_pkg::OP_LD_H:
                load_data = mem2_i.addr[0] ? '0 : {{16{half_sel[15]}}, half_sel};
            lsu_pkg::OP_LD_HU:
                load_data = mem2_i.addr[0] ? '0 : {16'b0, half_sel};
            default:
                load_data = cache_data;
        endcase
    end

    always_comb begin
        wb_d.valid = mem2_i.valid;
        wb_d.wreg  = mem2_i.wreg;
        wb_d.waddr = mem2_i.waddr;
        wb_d.wdata = load_op ? load_data : mem2_i.wdata;
    end

    // loads are ready once the cache answered, all else at once
    always_comb begin
        data_forward_o.wreg  = mem2_i.valid & mem2_i.wreg;
        data_forward_o.ok    = ~load_op | data_ok_i | data_already_ok;
        data_forward_o.waddr = mem2_i.waddr;
        data_forward_o.wdata = wb_d.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_o <= '0;
        end else if (advance_i) begin
            wb_o <= wb_d;
        end else begin
            // valid for a single cycle only
            wb_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsu_top #(
    parameter int DEPTH_LOG2 = 8,
    parameter int LATENCY    = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  lsu_pkg::lsu_req_t       req_i,
    output logic                    ready_o,
    output lsu_pkg::mem3_wb_t       wb_o,
    output lsu_pkg::data_forward_t  fwd_o
);
    logic                     advance;
    lsu_pkg::mem2_mem3_t      mem2_mem3;
    logic                     cache_req;
    logic                     cache_we;
    logic [lsu_pkg::XLEN-1:0] cache_addr;
    logic [3:0]               cache_wstrb;
    logic [lsu_pkg::XLEN-1:0] cache_wdata;
    logic                     cache_data_ok;
    logic [lsu_pkg::XLEN-1:0] cache_rdata;

    // single global advance
    assign ready_o = advance;

    mem2_stage u_mem2 (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance),
        .flush_i   (flush_i),
        .req_i     (req_i),
        .mem2_o    (mem2_mem3),
        .req_o     (cache_req),
        .we_o      (cache_we),
        .addr_o    (cache_addr),
        .wstrb_o   (cache_wstrb),
        .wdata_o   (cache_wdata)
    );

    dcache_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) u_dcache (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (flush_i),
        .req_i     (cache_req),
        .we_i      (cache_we),
        .addr_i    (cache_addr),
        .wstrb_i   (cache_wstrb),
        .wdata_i   (cache_wdata),
        .data_ok_o (cache_data_ok),
        .rdata_o   (cache_rdata)
    );

    mem3_stage u_mem3 (
        .clk             (clk),
        .rst             (rst),
        .advance_i       (advance),
        .flush_i         (flush_i),
        .mem2_i          (mem2_mem3),
        .data_ok_i       (cache_data_ok),
        .cache_data_i    (cache_rdata),
        .advance_ready_o (advance),
        .data_forward_o  (fwd_o),
        .wb_o            (wb_o)
    );

endmodule

`default_nettype wire

// ==== sim/lsu_chk.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsu_chk (
    input logic clk,
    input logic rst,
    input logic flush_i,
    input logic data_ok_i,
    input logic data_already_ok_i,
    input logic mem_access_valid_i,
    input logic wb_valid_i
);
    // failed assertion count
    int unsigned failures = 0;

    a_flag_after_data_ok: assert property (@(posedge clk) disable iff (rst)
        $rose(data_already_ok_i) |-> $past(data_ok_i))
    else begin
        $error("data_already_ok rose without data_ok");
        failures++;
    end

    // a cache response belongs to the access held in mem3
    a_data_ok_with_access: assert property (@(posedge clk) disable iff (rst)
        data_ok_i |-> mem_access_valid_i)
    else begin
        $error("data_ok with no memory access in mem3");
        failures++;
    end

    a_no_wb_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !wb_valid_i)
    else begin
        $error("wb valid in the cycle after flush");
        failures++;
    end

endmodule

bind mem3_stage lsu_chk u_chk (
    .clk                (clk),
    .rst                (rst),
    .flush_i            (flush_i),
    .data_ok_i          (data_ok_i),
    .data_already_ok_i  (data_already_ok),
    .mem_access_valid_i (mem2_i.mem_access_valid),
    .wb_valid_i         (wb_o.valid)
);

`default_nettype wire

// ==== sim/lsu_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsu_tb;
    localparam int DEPTH_LOG2 = 8;
    localparam int LATENCY    = 3;
    localparam int N_RANDOM   = 200;
    // about LATENCY + 5 cycles per instruction, directed tests count as 300 more
    localparam int MAX_CYCLES = (N_RANDOM + 300) * (LATENCY + 5);

    logic                   clk;
    logic                   rst;
    logic                   flush_i;
    lsu_pkg::lsu_req_t      req_i;
    logic                   ready_o;
    lsu_pkg::mem3_wb_t      wb_o;
    lsu_pkg::data_forward_t fwd_o;

    logic [7:0]        ref_mem [4 << DEPTH_LOG2];
    lsu_pkg::mem3_wb_t exp_q [$];
    logic [31:0]       rng_state = 32'hb6769d3b;
    int                cycles = 0;

    lsu_top #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .req_i   (req_i),
        .ready_o (ready_o),
        .wb_o    (wb_o),
        .fwd_o   (fwd_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(lsu_pkg::mem_op_e op, logic [31:0] addr,
                                                   logic [31:0] data, logic [4:0] waddr);
        return '{valid: 1'b1, op: op, addr: addr, wdata: data, wreg: 1'b1, waddr: waddr};
    endfunction

    // little endian byte memory, stores applied in program order
    function automatic logic [31:0] ref_access(lsu_pkg::lsu_req_t r);
        int          i;
        int          n;
        logic [31:0] word;
        i = int'(r.addr[DEPTH_LOG2+1:0]);
        n = (r.op == lsu_pkg::OP_ST_W) ? 4 : (r.op == lsu_pkg::OP_ST_H) ? 2 :
            (r.op == lsu_pkg::OP_ST_B) ? 1 : 0;
        for (int b = 0; b < n; b++)
            ref_mem[i + b] = r.wdata[8*b +: 8];
        for (int b = 0; b < 4; b++)
            word[8*b +: 8] = ref_mem[(i & ~3) + b];
        case (r.op)
            lsu_pkg::OP_LD_W:  return word;
            lsu_pkg::OP_LD_B:  return {{24{ref_mem[i][7]}}, ref_mem[i]};
            lsu_pkg::OP_LD_BU: return {24'b0, ref_mem[i]};
            lsu_pkg::OP_LD_H:
                return r.addr[0] ? '0 : {{16{ref_mem[i+1][7]}}, ref_mem[i+1], ref_mem[i]};
            lsu_pkg::OP_LD_HU: return r.addr[0] ? '0 : {16'b0, ref_mem[i+1], ref_mem[i]};
            default:           return r.wdata;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(lsu_pkg::mem3_wb_t got, lsu_pkg::mem3_wb_t want);
        if (got !== want) begin
            $display("ERR %0t wb_o got %h exp %h", $time, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_fwd(lsu_pkg::data_forward_t got, lsu_pkg::data_forward_t want);
        // data means nothing until ok
        if (!want.ok)
            got.wdata = want.wdata;
        if (got !== want) begin
            $display("ERR %0t fwd_o got %h exp %h", $time, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_ready(logic got, logic want);
        if (got !== want) begin
            $display("ERR %0t ready_o got %b exp %b", $time, got, want);
            stop_on_error();
        end
    endtask

    // hold r until the edge that captures it
    task automatic send(lsu_pkg::lsu_req_t r, bit retire = 1'b1);
        lsu_pkg::mem3_wb_t e;
        req_i <= r;
        @(posedge clk);
        while (!ready_o)
            @(posedge clk);
        if (retire) begin
            e = '{valid: 1'b1, wreg: r.wreg, waddr: r.waddr, wdata: ref_access(r)};
            exp_q.push_back(e);
        end
    endtask

    task automatic drain();
        req_i <= '0;
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic test_store_load();
        send(make_req(lsu_pkg::OP_ST_W, 32'h40, next_random(), 5'd1));
        send(make_req(lsu_pkg::OP_LD_W, 32'h40, 32'h0, 5'd2));
        drain();
    endtask

    // every offset, odd halfword offsets read as zero
    task automatic test_lanes();
        logic [31:0] a;
        for (int w = 0; w < 4; w++) begin
            a = 32'h80 + 32'(4 * w);
            send(make_req(lsu_pkg::OP_ST_W, a, next_random(), 5'd3));
            send(make_req(lsu_pkg::OP_ST_B, a + 32'(w), next_random(), 5'd4));
            send(make_req(lsu_pkg::OP_ST_H, a + 32'(2 * (w % 2)), next_random(), 5'd4));
            for (int off = 0; off < 4; off++) begin
                send(make_req(lsu_pkg::OP_LD_B, a + 32'(off), 32'h0, 5'd5));
                send(make_req(lsu_pkg::OP_LD_BU, a + 32'(off), 32'h0, 5'd6));
                send(make_req(lsu_pkg::OP_LD_H, a + 32'(off), 32'h0, 5'd7));
                send(make_req(lsu_pkg::OP_LD_HU, a + 32'(off), 32'h0, 5'd8));
            end
        end
        drain();
    endtask

    task automatic test_stall();
        lsu_pkg::data_forward_t f;
        logic [31:0]            ld_val;
        send(make_req(lsu_pkg::OP_ST_W, 32'h100, next_random(), 5'd6));
        send(make_req(lsu_pkg::OP_LD_W, 32'h100, 32'h0, 5'd7));
        ld_val = exp_q[exp_q.size()-1].wdata;
        send(make_req(lsu_pkg::OP_NOP, 32'h0, next_random(), 5'd8));
        req_i <= '0;
        f = '{wreg: 1'b1, ok: 1'b0, waddr: 5'd7, wdata: ld_val};
        @(posedge clk);
        check_ready(ready_o, 1'b0);
        while (!ready_o) begin
            check_fwd(fwd_o, f);
            @(posedge clk);
        end
        f.ok = 1'b1;
        check_fwd(fwd_o, f);
        drain();
    endtask

    task automatic test_flush();
        send(make_req(lsu_pkg::OP_ST_W, 32'h140, next_random(), 5'd9));
        drain();
        send(make_req(lsu_pkg::OP_LD_W, 32'h140, 32'h0, 5'd10), 1'b0);
        send(make_req(lsu_pkg::OP_NOP, 32'h0, next_random(), 5'd11), 1'b0);
        req_i   <= '0;
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        // any write-back here is caught by the monitor
        repeat (LATENCY + 4) @(posedge clk);
        check_ready(ready_o, 1'b1);
        send(make_req(lsu_pkg::OP_LD_W, 32'h140, 32'h0, 5'd12));
        send(make_req(lsu_pkg::OP_LD_B, 32'h143, 32'h0, 5'd13));
        drain();
    endtask

    task automatic test_random();
        lsu_pkg::lsu_req_t r;
        logic [31:0]       x;
        for (int i = 0; i < 16; i++)
            send(make_req(lsu_pkg::OP_ST_W, 32'h200 + 32'(4 * i), next_random(), 5'd0));
        for (int n = 0; n < N_RANDOM; n++) begin
            x = next_random();
            r = make_req(lsu_pkg::OP_NOP, 32'h200 + {26'b0, x[5:0]}, next_random(), x[10:6]);
            r.wreg = x[11];
            case (x[15:12] % 4'd9)
                4'd0: r.op = lsu_pkg::OP_LD_B;
                4'd1: r.op = lsu_pkg::OP_LD_H;
                4'd2: begin
                    r.op        = lsu_pkg::OP_LD_W;
                    r.addr[1:0] = 2'b00;
                end
                4'd3: r.op = lsu_pkg::OP_LD_BU;
                4'd4: r.op = lsu_pkg::OP_LD_HU;
                4'd5: r.op = lsu_pkg::OP_ST_B;
                4'd6: begin
                    r.op      = lsu_pkg::OP_ST_H;
                    r.addr[0] = 1'b0;
                end
                4'd7: begin
                    r.op        = lsu_pkg::OP_ST_W;
                    r.addr[1:0] = 2'b00;
                end
                default: r.op = lsu_pkg::OP_NOP;
            endcase
            send(r);
            if (x[16]) begin
                req_i <= '0;
                @(posedge clk);
            end
        end
        drain();
    endtask

    // write-back monitor, in program order
    always @(posedge clk) begin : wb_monitor
        lsu_pkg::mem3_wb_t e;
        if (!rst && wb_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("write-back at %0t with no instruction outstanding", $time);
                stop_on_error();
            end else begin
                e = exp_q.pop_front();
                check_wb(wb_o, e);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (DUT.u_mem3.u_chk.failures != 0) begin
            $display("an assertion on the mem3 stage failed");
            stop_on_error();
        end else if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    initial begin
        rst     <= 1'b1;
        flush_i <= 1'b0;
        req_i   <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_ready(ready_o, 1'b1);
        test_store_load();
        test_lanes();
        test_stall();
        test_flush();
        test_random();
        if (exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d expected write-backs never appeared", exp_q.size());
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/lsu_pkg.sv
hdl/mem2_stage.sv
hdl/dcache_ram.sv
hdl/mem3_stage.sv
hdl/lsu_top.sv
sim/lsu_chk.sv
sim/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := lsu_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_FLAGS := +verilator+error+limit+100
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
